// File: all.f
mac_table_pkg.sv
mac_table_ram.sv
mac_dst_lookup.sv
mac_learn_queue.sv
mac_port_arbiter.sv
mac_gc_fsm.sv
mac_address_table.sv
tb_mac_address_table.sv

// File: mac_address_table.sv
`timescale 1ns/1ps

module mac_address_table
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS  = 16,
	parameter int  ASSOC_WAYS  = 4,
	parameter int  QUEUE_DEPTH = 4,
	localparam int ROW_W       = $clog2(TABLE_ROWS),
	localparam int WAY_W       = $clog2(ASSOC_WAYS)
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  lookup_en,
	input  vlan_t lookup_vlan,
	input  mac_t  lookup_src_mac,
	input  port_t lookup_src_port,
	input  mac_t  lookup_dst_mac,
	output logic  lookup_done,
	output logic  lookup_hit,
	output port_t lookup_dst_port,
	input  logic  gc_en,
	output logic  gc_done
);

	hash_t            src_hash;
	hash_t            dst_hash;
	logic [ROW_W-1:0] src_row;
	logic [ROW_W-1:0] dst_row;

	// Per-way read data, port A for lookups and port B for the engines
	entry_t a_rdata [ASSOC_WAYS];
	entry_t b_rdata [ASSOC_WAYS];

	// Port B, shared by all ways
	logic                  b_en;
	logic [ASSOC_WAYS-1:0] b_we;
	logic [ROW_W-1:0]      b_addr;
	entry_t                b_wdata;

	// Learning queue writes
	logic             q_req;
	logic [ROW_W-1:0] q_row;
	logic [WAY_W-1:0] q_way;
	entry_t           q_data;
	logic             q_grant;

	// Mark refresh writes
	logic             ref_req;
	logic [ROW_W-1:0] ref_row;
	logic [WAY_W-1:0] ref_way;
	entry_t           ref_data;
	logic             ref_grant;

	// Garbage collector traffic
	logic             gc_rd_req;
	logic             gc_wr_req;
	logic [ROW_W-1:0] gc_row;
	logic [WAY_W-1:0] gc_way;
	entry_t           gc_data;
	logic             gc_rd_grant;
	logic             gc_wr_grant;

	// Source and destination share the frame VLAN
	assign src_hash = mac_hash(lookup_src_mac, lookup_vlan);
	assign dst_hash = mac_hash(lookup_dst_mac, lookup_vlan);
	assign src_row  = src_hash[ROW_W-1:0];
	assign dst_row  = dst_hash[ROW_W-1:0];

	////////////////////////////////////////////////////////////////////////////
	// Table ways

	for (genvar g = 0; g < ASSOC_WAYS; g++) begin : g_way
		mac_table_ram #(.TABLE_ROWS(TABLE_ROWS)) u_ram (
			.clk(clk), .a_en(lookup_en), .a_addr(dst_row), .a_rdata(a_rdata[g]),
			.b_en(b_en), .b_we(b_we[g]), .b_addr(b_addr), .b_wdata(b_wdata),
			.b_rdata(b_rdata[g])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Engines

	mac_dst_lookup #(.TABLE_ROWS(TABLE_ROWS), .ASSOC_WAYS(ASSOC_WAYS)) u_dst (
		.clk(clk), .arst_n(arst_n), .lookup_en(lookup_en), .dst_mac(lookup_dst_mac),
		.vlan(lookup_vlan), .dst_row(dst_row), .way_rdata(a_rdata),
		.lookup_done(lookup_done), .lookup_hit(lookup_hit), .lookup_dst_port(lookup_dst_port),
		.refresh_req(ref_req), .refresh_row(ref_row), .refresh_way(ref_way),
		.refresh_data(ref_data), .refresh_grant(ref_grant)
	);

	mac_learn_queue #(
		.TABLE_ROWS(TABLE_ROWS), .ASSOC_WAYS(ASSOC_WAYS), .QUEUE_DEPTH(QUEUE_DEPTH)
	) u_learn (
		.clk(clk), .arst_n(arst_n), .lookup_en(lookup_en), .src_mac(lookup_src_mac),
		.vlan(lookup_vlan), .src_port(lookup_src_port), .way_rdata(b_rdata),
		.wr_req(q_req), .wr_row(q_row), .wr_way(q_way), .wr_data(q_data), .wr_grant(q_grant)
	);

	mac_port_arbiter #(.TABLE_ROWS(TABLE_ROWS), .ASSOC_WAYS(ASSOC_WAYS)) u_arb (
		.lookup_en(lookup_en), .src_row(src_row),
		.q_req(q_req), .q_row(q_row), .q_way(q_way), .q_data(q_data), .q_grant(q_grant),
		.ref_req(ref_req), .ref_row(ref_row), .ref_way(ref_way), .ref_data(ref_data),
		.ref_grant(ref_grant), .gc_rd_req(gc_rd_req), .gc_wr_req(gc_wr_req),
		.gc_row(gc_row), .gc_way(gc_way), .gc_data(gc_data),
		.gc_rd_grant(gc_rd_grant), .gc_wr_grant(gc_wr_grant),
		.b_en(b_en), .b_we(b_we), .b_addr(b_addr), .b_wdata(b_wdata)
	);

	mac_gc_fsm #(.TABLE_ROWS(TABLE_ROWS), .ASSOC_WAYS(ASSOC_WAYS)) u_gc (
		.clk(clk), .arst_n(arst_n), .gc_en(gc_en), .way_rdata(b_rdata),
		.gc_rd_req(gc_rd_req), .gc_wr_req(gc_wr_req), .gc_row(gc_row), .gc_way(gc_way),
		.gc_data(gc_data), .rd_grant(gc_rd_grant), .wr_grant(gc_wr_grant), .gc_done(gc_done)
	);

endmodule

// File: mac_dst_lookup.sv
`timescale 1ns/1ps

module mac_dst_lookup
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS = 16,
	parameter int  ASSOC_WAYS = 4,
	localparam int ROW_W      = $clog2(TABLE_ROWS),
	localparam int WAY_W      = $clog2(ASSOC_WAYS)
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             lookup_en,
	input  mac_t             dst_mac,
	input  vlan_t            vlan,
	input  logic [ROW_W-1:0] dst_row,
	input  entry_t           way_rdata [ASSOC_WAYS],
	output logic             lookup_done,
	output logic             lookup_hit,
	output port_t            lookup_dst_port,
	output logic             refresh_req,
	output logic [ROW_W-1:0] refresh_row,
	output logic [WAY_W-1:0] refresh_way,
	output entry_t           refresh_data,
	input  logic             refresh_grant
);

	// Request fields, two stages to line up with RAM data
	logic             en_ff;
	logic             en_ff2;
	mac_t             mac_ff;
	mac_t             mac_ff2;
	vlan_t            vlan_ff;
	vlan_t            vlan_ff2;
	logic [ROW_W-1:0] row_ff;
	logic [ROW_W-1:0] row_ff2;

	logic             hit_comb;
	logic             refresh_comb;
	port_t            port_comb;
	logic [WAY_W-1:0] way_comb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_ff  <= 1'b0;
			en_ff2 <= 1'b0;
		end else begin
			en_ff  <= lookup_en;
			en_ff2 <= en_ff;
		end
	end

	always_ff @(posedge clk) begin
		mac_ff   <= dst_mac;
		mac_ff2  <= mac_ff;
		vlan_ff  <= vlan;
		vlan_ff2 <= vlan_ff;
		row_ff   <= dst_row;
		row_ff2  <= row_ff;
	end

	////////////////////////////////////////////////////////////////////////////
	// Match across all ways

	always_comb begin
		hit_comb     = 1'b0;
		refresh_comb = 1'b0;
		port_comb    = '0;
		way_comb     = '0;
		if (en_ff2) begin
			// More than one hit should not happen, highest way wins
			for (int i = 0; i < ASSOC_WAYS; i++) begin
				if (way_rdata[i].valid && way_rdata[i].vlan == vlan_ff2 &&
						way_rdata[i].mac == mac_ff2) begin
					hit_comb     = 1'b1;
					port_comb    = way_rdata[i].port;
					way_comb     = WAY_W'(i);
					// Mark only needs a write when it is clear
					refresh_comb = !way_rdata[i].gc_mark;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lookup_done <= 1'b0;
			lookup_hit  <= 1'b0;
			refresh_req <= 1'b0;
		end else begin
			lookup_done <= en_ff2;
			lookup_hit  <= hit_comb;
			// A newer refresh takes over a waiting one
			if (refresh_comb) begin
				refresh_req <= 1'b1;
			end else if (refresh_grant) begin
				refresh_req <= 1'b0;
			end
		end
	end

	// Port is zero on a miss
	always_ff @(posedge clk) begin
		lookup_dst_port <= port_comb;
		if (refresh_comb) begin
			refresh_row          <= row_ff2;
			refresh_way          <= way_comb;
			refresh_data         <= way_rdata[way_comb];
			refresh_data.gc_mark <= 1'b1;
		end
	end

	a_hit_with_done: assert property (@(posedge clk) disable iff (!arst_n)
		lookup_hit |-> lookup_done);

endmodule

// File: mac_gc_fsm.sv
`timescale 1ns/1ps

module mac_gc_fsm
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS = 16,
	parameter int  ASSOC_WAYS = 4,
	localparam int ROW_W      = $clog2(TABLE_ROWS),
	localparam int WAY_W      = $clog2(ASSOC_WAYS)
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             gc_en,
	input  entry_t           way_rdata [ASSOC_WAYS],
	output logic             gc_rd_req,
	output logic             gc_wr_req,
	output logic [ROW_W-1:0] gc_row,
	output logic [WAY_W-1:0] gc_way,
	output entry_t           gc_data,
	input  logic             rd_grant,
	input  logic             wr_grant,
	output logic             gc_done
);

	gc_state_t state;
	// Granted read still in the RAM pipeline
	logic      rd_fly;
	entry_t    cur;

	assign cur = way_rdata[gc_way];

	////////////////////////////////////////////////////////////////////////////
	// Sweep over every row of every way

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= GC_IDLE;
			gc_rd_req <= 1'b0;
			gc_wr_req <= 1'b0;
			gc_row    <= '0;
			gc_way    <= '0;
			rd_fly    <= 1'b0;
			gc_done   <= 1'b0;
		end else begin
			gc_done <= 1'b0;
			case (state)
				GC_IDLE: begin
					if (gc_en) begin
						gc_row    <= '0;
						gc_way    <= '0;
						gc_rd_req <= 1'b1;
						state     <= GC_READ_WAIT;
					end
				end
				// Grant, then one more cycle until the data shows up
				GC_READ_WAIT: begin
					if (rd_grant) begin
						gc_rd_req <= 1'b0;
						rd_fly    <= 1'b1;
					end
					if (rd_fly) begin
						rd_fly <= 1'b0;
						state  <= GC_READ_VALID;
					end
				end
				GC_READ_VALID: begin
					// Empty slot, nothing to write
					if (!cur.valid) begin
						state <= GC_NEXT;
					end else begin
						gc_wr_req <= 1'b1;
						state     <= GC_WRITE_WAIT;
					end
				end
				GC_WRITE_WAIT: begin
					if (wr_grant) begin
						gc_wr_req <= 1'b0;
						state     <= GC_NEXT;
					end
				end
				GC_NEXT: begin
					if (gc_row == ROW_W'(TABLE_ROWS - 1)) begin
						gc_row <= '0;
						if (gc_way == WAY_W'(ASSOC_WAYS - 1)) begin
							gc_done <= 1'b1;
							state   <= GC_IDLE;
						end else begin
							gc_way    <= gc_way + 1'b1;
							gc_rd_req <= 1'b1;
							state     <= GC_READ_WAIT;
						end
					end else begin
						gc_row    <= gc_row + 1'b1;
						gc_rd_req <= 1'b1;
						state     <= GC_READ_WAIT;
					end
				end
				default: state <= GC_IDLE;
			endcase
		end
	end

	// Marked entries survive unmarked, unmarked ones are wiped
	always_ff @(posedge clk) begin
		if (state == GC_READ_VALID) begin
			if (cur.gc_mark) begin
				gc_data         <= cur;
				gc_data.gc_mark <= 1'b0;
			end else begin
				gc_data <= '0;
			end
		end
	end

endmodule

// File: mac_learn_queue.sv
`timescale 1ns/1ps

module mac_learn_queue
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS  = 16,
	parameter int  ASSOC_WAYS  = 4,
	parameter int  QUEUE_DEPTH = 4,
	localparam int ROW_W       = $clog2(TABLE_ROWS),
	localparam int WAY_W       = $clog2(ASSOC_WAYS),
	localparam int SLOT_W      = $clog2(QUEUE_DEPTH)
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             lookup_en,
	input  mac_t             src_mac,
	input  vlan_t            vlan,
	input  port_t            src_port,
	input  entry_t           way_rdata [ASSOC_WAYS],
	output logic             wr_req,
	output logic [ROW_W-1:0] wr_row,
	output logic [WAY_W-1:0] wr_way,
	output entry_t           wr_data,
	input  logic             wr_grant
);

	// Source pipeline
	logic  en_ff;
	logic  en_ff2;
	mac_t  mac_ff;
	mac_t  mac_ff2;
	vlan_t vlan_ff;
	vlan_t vlan_ff2;
	port_t port_ff;
	port_t port_ff2;

	// Queue slots, entries held with mark and valid already set
	logic [QUEUE_DEPTH-1:0] q_valid;
	entry_t                 q_ent [QUEUE_DEPTH];
	logic [WAY_W-1:0]       q_way [QUEUE_DEPTH];

	// Rotating replacement way
	logic [WAY_W-1:0]  rr_way;

	// Entry written last cycle, not yet seen in read data
	entry_t            wr_last;
	logic              wr_last_v;

	logic              known;
	logic              queued;
	logic              has_free;
	logic              push;
	logic [SLOT_W-1:0] free_slot;
	logic [SLOT_W-1:0] wr_slot;
	hash_t             wr_hash;

	////////////////////////////////////////////////////////////////////////////
	// Source check

	always_comb begin
		known     = 1'b0;
		queued    = 1'b0;
		has_free  = 1'b0;
		free_slot = '0;
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			if (way_rdata[i].valid && way_rdata[i].vlan == vlan_ff2 &&
					way_rdata[i].mac == mac_ff2) begin
				known = 1'b1;
			end
		end
		if (wr_last_v && wr_last.vlan == vlan_ff2 && wr_last.mac == mac_ff2) begin
			known = 1'b1;
		end
		// Walk down so the lowest free slot is picked
		for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
			if (q_valid[i] && q_ent[i].vlan == vlan_ff2 && q_ent[i].mac == mac_ff2) begin
				queued = 1'b1;
			end
			if (!q_valid[i]) begin
				has_free  = 1'b1;
				free_slot = SLOT_W'(i);
			end
		end
		// Full queue drops the source
		push = en_ff2 && !known && !queued && has_free;
	end

	////////////////////////////////////////////////////////////////////////////
	// Queue drain, lowest valid slot first

	always_comb begin
		wr_slot = '0;
		for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
			if (q_valid[i]) begin
				wr_slot = SLOT_W'(i);
			end
		end
		wr_hash = mac_hash(q_ent[wr_slot].mac, q_ent[wr_slot].vlan);
	end

	assign wr_req  = |q_valid;
	assign wr_row  = wr_hash[ROW_W-1:0];
	assign wr_way  = q_way[wr_slot];
	assign wr_data = q_ent[wr_slot];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_ff     <= 1'b0;
			en_ff2    <= 1'b0;
			q_valid   <= '0;
			rr_way    <= '0;
			wr_last_v <= 1'b0;
		end else begin
			en_ff     <= lookup_en;
			en_ff2    <= en_ff;
			wr_last_v <= wr_grant;
			if (wr_grant) begin
				q_valid[wr_slot] <= 1'b0;
			end
			if (push) begin
				q_valid[free_slot] <= 1'b1;
				rr_way             <= rr_way + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		mac_ff   <= src_mac;
		mac_ff2  <= mac_ff;
		vlan_ff  <= vlan;
		vlan_ff2 <= vlan_ff;
		port_ff  <= src_port;
		port_ff2 <= port_ff;
		wr_last  <= wr_data;
		if (push) begin
			q_ent[free_slot] <= '{gc_mark: 1'b1, valid: 1'b1, vlan: vlan_ff2,
				port: port_ff2, mac: mac_ff2};
			q_way[free_slot] <= rr_way;
		end
	end

	a_write_slot_valid: assert property (@(posedge clk) disable iff (!arst_n)
		wr_grant |-> q_valid[wr_slot]);

endmodule

// File: mac_port_arbiter.sv
`timescale 1ns/1ps

module mac_port_arbiter
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS = 16,
	parameter int  ASSOC_WAYS = 4,
	localparam int ROW_W      = $clog2(TABLE_ROWS),
	localparam int WAY_W      = $clog2(ASSOC_WAYS)
) (
	input  logic                  lookup_en,
	input  logic [ROW_W-1:0]      src_row,
	input  logic                  q_req,
	input  logic [ROW_W-1:0]      q_row,
	input  logic [WAY_W-1:0]      q_way,
	input  entry_t                q_data,
	output logic                  q_grant,
	input  logic                  ref_req,
	input  logic [ROW_W-1:0]      ref_row,
	input  logic [WAY_W-1:0]      ref_way,
	input  entry_t                ref_data,
	output logic                  ref_grant,
	input  logic                  gc_rd_req,
	input  logic                  gc_wr_req,
	input  logic [ROW_W-1:0]      gc_row,
	input  logic [WAY_W-1:0]      gc_way,
	input  entry_t                gc_data,
	output logic                  gc_rd_grant,
	output logic                  gc_wr_grant,
	output logic                  b_en,
	output logic [ASSOC_WAYS-1:0] b_we,
	output logic [ROW_W-1:0]      b_addr,
	output entry_t                b_wdata
);

	// Fixed priority, source read first and GC last
	always_comb begin
		b_en        = 1'b0;
		b_we        = '0;
		b_addr      = '0;
		b_wdata     = '0;
		q_grant     = 1'b0;
		ref_grant   = 1'b0;
		gc_rd_grant = 1'b0;
		gc_wr_grant = 1'b0;
		if (lookup_en) begin
			// Source lookup owns the port, nothing is written
			b_en   = 1'b1;
			b_addr = src_row;
		end else if (q_req) begin
			b_en        = 1'b1;
			b_we[q_way] = 1'b1;
			b_addr      = q_row;
			b_wdata     = q_data;
			q_grant     = 1'b1;
		end else if (ref_req) begin
			b_en          = 1'b1;
			b_we[ref_way] = 1'b1;
			b_addr        = ref_row;
			b_wdata       = ref_data;
			ref_grant     = 1'b1;
		end else if (gc_rd_req) begin
			b_en        = 1'b1;
			b_addr      = gc_row;
			gc_rd_grant = 1'b1;
		end else if (gc_wr_req) begin
			b_en         = 1'b1;
			b_we[gc_way] = 1'b1;
			b_addr       = gc_row;
			b_wdata      = gc_data;
			gc_wr_grant  = 1'b1;
		end
	end

	// GC shares one row and way between its read and write
	always_comb begin
		a_gc_req_exclusive: assert (!(gc_rd_req && gc_wr_req))
			else $error("GC read and write requested together");
	end

endmodule

// File: mac_table_pkg.sv
package mac_table_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths

	localparam int MAC_W  = 48;
	localparam int VLAN_W = 12;
	localparam int PORT_W = 5;
	// Wide enough for 64K rows per way
	localparam int HASH_W = 16;

	typedef logic [MAC_W-1:0]  mac_t;
	typedef logic [VLAN_W-1:0] vlan_t;
	typedef logic [PORT_W-1:0] port_t;
	typedef logic [HASH_W-1:0] hash_t;

	////////////////////////////////////////////////////////////////////////////
	// Table entry, 67 bits

	typedef struct packed {
		// Set by forwarding, cleared by the sweep
		logic  gc_mark;
		logic  valid;
		vlan_t vlan;
		port_t port;
		mac_t  mac;
	} entry_t;

	// XOR fold of the address with the VLAN
	// Callers keep only the low row bits
	function automatic hash_t mac_hash(input mac_t mac, input vlan_t vlan);
		return mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ HASH_W'(vlan);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Garbage collector states

	typedef enum logic [2:0] {
		GC_IDLE,
		GC_READ_WAIT,
		GC_READ_VALID,
		GC_WRITE_WAIT,
		GC_NEXT
	} gc_state_t;

endpackage

// File: mac_table_ram.sv
`timescale 1ns/1ps

module mac_table_ram
	import mac_table_pkg::*;
#(
	parameter int  TABLE_ROWS = 16,
	localparam int ROW_W      = $clog2(TABLE_ROWS)
) (
	input  logic             clk,
	input  logic             a_en,
	input  logic [ROW_W-1:0] a_addr,
	output entry_t           a_rdata,
	input  logic             b_en,
	input  logic             b_we,
	input  logic [ROW_W-1:0] b_addr,
	input  entry_t           b_wdata,
	output entry_t           b_rdata
);

	entry_t mem [TABLE_ROWS];
	// First output stage of each port
	entry_t a_stage;
	entry_t b_stage;

	// Table starts out empty
	initial begin
		for (int i = 0; i < TABLE_ROWS; i++) begin
			mem[i] = '0;
		end
	end

	// Lookup port, read only
	always_ff @(posedge clk) begin
		if (a_en) begin
			a_stage <= mem[a_addr];
		end
		a_rdata <= a_stage;
	end

	// Internal port, read-first
	always_ff @(posedge clk) begin
		if (b_en) begin
			if (b_we) begin
				mem[b_addr] <= b_wdata;
			end
			b_stage <= mem[b_addr];
		end
		b_rdata <= b_stage;
	end

	// Writes come only from port B and never land in a lookup cycle
	a_no_write_on_lookup: assert property (@(posedge clk) a_en |-> !(b_en && b_we));

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the MAC table testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_mac_address_table -f all.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
	echo "RESULT: PASS"
	exit 0
fi
echo "RESULT: FAIL"
exit 1

// File: tb_mac_address_table.sv
`timescale 1ns/1ps

module tb_mac_address_table
	import mac_table_pkg::*;
();

	localparam int TABLE_ROWS  = 16;
	localparam int ASSOC_WAYS  = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int ROW_W       = $clog2(TABLE_ROWS);
	localparam int GC_LIMIT    = ASSOC_WAYS * TABLE_ROWS * 8;

	// Host indices, host i sits in row i of its VLAN
	localparam int N_HOSTS = 15;
	localparam int H_A     = 0;
	localparam int H_B     = 1;
	localparam int H_G     = 2;
	localparam int H_D     = 3;
	localparam int H_E     = 4;
	localparam int H_S0    = 5;

	// Same low bits, so a MAC maps to the same row in both VLANs
	localparam vlan_t VLAN_A = 12'h00A;
	localparam vlan_t VLAN_B = 12'h0BA;

	typedef struct {
		logic  is_gc;
		vlan_t vlan;
		mac_t  src;
		port_t sport;
		mac_t  dst;
		int    gap;
		logic  exp_done;
		logic  exp_hit;
		port_t exp_port;
	} row_t;

	logic  clk;
	logic  arst_n;
	logic  lookup_en;
	vlan_t lookup_vlan;
	mac_t  lookup_src_mac;
	port_t lookup_src_port;
	mac_t  lookup_dst_mac;
	logic  lookup_done;
	logic  lookup_hit;
	port_t lookup_dst_port;
	logic  gc_en;
	logic  gc_done;

	// Expected result of the frame on the inputs this cycle
	logic  drv_done;
	logic  drv_hit;
	port_t drv_port;

	// Three-stage model of the lookup latency
	logic  pipe_v    [3];
	logic  pipe_done [3];
	logic  pipe_hit  [3];
	port_t pipe_port [3];

	row_t        tab [$];
	mac_t        host_mac  [N_HOSTS];
	vlan_t       host_vlan [N_HOSTS];
	port_t       host_port [N_HOSTS];
	mac_t        stranger;
	logic [15:0] lfsr;
	int          watch_cycles = 0;
	int          err_bit      = 0;
	int          err_port     = 0;
	int          err_gc       = 0;

	mac_address_table #(
		.TABLE_ROWS(TABLE_ROWS), .ASSOC_WAYS(ASSOC_WAYS), .QUEUE_DEPTH(QUEUE_DEPTH)
	) dut0 (
		.clk(clk), .arst_n(arst_n), .lookup_en(lookup_en), .lookup_vlan(lookup_vlan),
		.lookup_src_mac(lookup_src_mac), .lookup_src_port(lookup_src_port),
		.lookup_dst_mac(lookup_dst_mac), .lookup_done(lookup_done), .lookup_hit(lookup_hit),
		.lookup_dst_port(lookup_dst_port), .gc_en(gc_en), .gc_done(gc_done)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Random addresses and the row rule

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per address bit
	task automatic next_mac(output mac_t m);
		m = '0;
		for (int b = 0; b < MAC_W; b++) begin
			lfsr = lfsr_step(lfsr);
			m    = {m[MAC_W-2:0], lfsr[0]};
		end
	endtask

	// Fold of the three address slices and the VLAN, low bits kept
	function automatic logic [ROW_W-1:0] row_of(input mac_t m, input vlan_t v);
		logic [15:0] h;
		h = m[47:32] ^ m[31:16] ^ m[15:0] ^ {4'b0, v};
		return h[ROW_W-1:0];
	endfunction

	task automatic make_hosts();
		mac_t             m;
		logic [ROW_W-1:0] r;
		for (int i = 0; i < N_HOSTS; i++) begin
			next_mac(m);
			host_vlan[i] = (i == H_G) ? VLAN_B : VLAN_A;
			r            = row_of(m, host_vlan[i]);
			// Flip low bits so the row becomes i
			m[ROW_W-1:0] = m[ROW_W-1:0] ^ r ^ ROW_W'(i);
			host_mac[i]  = m;
			host_port[i] = PORT_W'(i + 1);
		end
		// Destination only, never a source
		next_mac(stranger);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table

	// dst below zero looks up the stranger
	task automatic add_frame(input int src, input int dst, input int gap, input logic hit);
		row_t r;
		r.is_gc    = 1'b0;
		r.vlan     = host_vlan[src];
		r.src      = host_mac[src];
		r.sport    = host_port[src];
		r.dst      = (dst < 0) ? stranger : host_mac[dst];
		r.gap      = gap;
		r.exp_done = 1'b1;
		r.exp_hit  = hit;
		r.exp_port = hit ? host_port[dst] : '0;
		tab.push_back(r);
	endtask

	task automatic add_sweep(input int gap);
		row_t r;
		r.is_gc    = 1'b1;
		r.vlan     = '0;
		r.src      = '0;
		r.sport    = '0;
		r.dst      = '0;
		r.gap      = gap;
		r.exp_done = 1'b0;
		r.exp_hit  = 1'b0;
		r.exp_port = '0;
		tab.push_back(r);
	endtask

	task automatic build_table();
		// Empty table
		add_frame(H_A, -1, 0, 1'b0);
		add_frame(H_B, -1, 8, 1'b0);
		// Learned hosts, then A looked up from VLAN B
		add_frame(H_A, H_B, 4, 1'b1);
		add_frame(H_B, H_A, 4, 1'b1);
		add_frame(H_G, H_A, 8, 1'b0);
		// Back to back lookups
		add_frame(H_A, H_B, 0, 1'b1);
		add_frame(H_B, H_A, 0, 1'b1);
		add_frame(H_G, H_G, 0, 1'b1);
		add_frame(H_A, H_A, 0, 1'b1);
		add_frame(H_B, H_B, 4, 1'b1);
		// D four times, E must still find a slot
		for (int k = 0; k < 4; k++) begin
			add_frame(H_D, -1, 0, 1'b0);
		end
		add_frame(H_E, -1, 0, 1'b0);
		add_frame(H_A, H_B, 0, 1'b1);
		add_frame(H_A, H_B, 8, 1'b1);
		add_frame(H_A, H_D, 4, 1'b1);
		add_frame(H_A, H_E, 4, 1'b1);
		// Ten new sources, queue holds four
		for (int k = 0; k < 10; k++) begin
			add_frame(H_S0 + k, -1, (k == 9) ? 12 : 0, 1'b0);
		end
		for (int k = 0; k < 7; k++) begin
			add_frame(H_A, H_S0 + k, (k == 6) ? 4 : 0, k < 4);
		end
		// First sweep clears every mark
		add_sweep(4);
		// Gaps let each refresh write land
		add_frame(H_A, H_A, 4, 1'b1);
		add_frame(H_A, H_D, 4, 1'b1);
		add_frame(H_A, H_S0, 4, 1'b1);
		add_sweep(4);
		// Survivors of the second sweep
		add_frame(H_A, H_A, 0, 1'b1);
		add_frame(H_A, H_D, 0, 1'b1);
		add_frame(H_A, H_S0, 0, 1'b1);
		add_frame(H_A, H_B, 0, 1'b0);
		add_frame(H_A, H_E, 0, 1'b0);
		for (int k = 1; k < 4; k++) begin
			add_frame(H_A, H_S0 + k, (k == 3) ? 4 : 0, 1'b0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %0b expected %0b", $time, name, got, exp);
			err_bit++;
		end
	endtask

	task automatic check_port(input string name, input port_t got, input port_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
			err_port++;
		end
	endtask

	task automatic check_gc(input logic got, input int waited);
		if (got !== 1'b1) begin
			$display("Sweep started before t=%0t gave no gc_done within %0d cycles", $time, waited);
			err_gc++;
		end
	endtask

	task automatic print_counts();
		$display("Errors: %0d done/hit, %0d port, %0d gc", err_bit, err_port, err_gc);
	endtask

	// Waits on falling edges where gc_done is settled
	task automatic wait_gc();
		int waited;
		waited = 0;
		@(negedge clk);
		while (gc_done !== 1'b1 && waited < GC_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		check_gc(gc_done, waited);
	endtask

	// Result due three cycles after each request
	always @(negedge clk) begin
		check_bit("lookup_done", lookup_done, pipe_v[2] && pipe_done[2]);
		if (pipe_v[2] && pipe_done[2]) begin
			check_bit("lookup_hit", lookup_hit, pipe_hit[2]);
			if (pipe_hit[2]) begin
				check_port("lookup_dst_port", lookup_dst_port, pipe_port[2]);
			end
		end
		for (int s = 2; s > 0; s--) begin
			pipe_v[s]    = pipe_v[s-1];
			pipe_done[s] = pipe_done[s-1];
			pipe_hit[s]  = pipe_hit[s-1];
			pipe_port[s] = pipe_port[s-1];
		end
		pipe_v[0]    = lookup_en;
		pipe_done[0] = drv_done;
		pipe_hit[0]  = drv_hit;
		pipe_port[0] = drv_port;
	end

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", watch_cycles);
		print_counts();
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		clk             = 1'b0;
		arst_n          = 1'b0;
		lookup_en       = 1'b0;
		lookup_vlan     = '0;
		lookup_src_mac  = '0;
		lookup_src_port = '0;
		lookup_dst_mac  = '0;
		gc_en           = 1'b0;
		drv_done        = 1'b0;
		drv_hit         = 1'b0;
		drv_port        = '0;
		for (int s = 0; s < 3; s++) begin
			pipe_v[s]    = 1'b0;
			pipe_done[s] = 1'b0;
			pipe_hit[s]  = 1'b0;
			pipe_port[s] = '0;
		end
		lfsr = 16'd11987;
		make_hosts();
		build_table();
		// Reset, every row with its gap, two sweeps, margin
		watch_cycles = 16 + 2 * ASSOC_WAYS * TABLE_ROWS * 8 + 200;
		foreach (tab[i]) begin
			watch_cycles += 1 + tab[i].gap;
		end

		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk);

		for (int i = 0; i < tab.size(); i++) begin
			@(posedge clk);
			if (tab[i].is_gc) begin
				lookup_en <= 1'b0;
				gc_en     <= 1'b1;
				@(posedge clk);
				gc_en <= 1'b0;
				wait_gc();
			end else begin
				lookup_en       <= 1'b1;
				lookup_vlan     <= tab[i].vlan;
				lookup_src_mac  <= tab[i].src;
				lookup_src_port <= tab[i].sport;
				lookup_dst_mac  <= tab[i].dst;
				drv_done        <= tab[i].exp_done;
				drv_hit         <= tab[i].exp_hit;
				drv_port        <= tab[i].exp_port;
			end
			repeat (tab[i].gap) begin
				@(posedge clk);
				lookup_en <= 1'b0;
			end
		end
		@(posedge clk);
		lookup_en <= 1'b0;
		// Drain the result pipeline
		repeat (8) @(posedge clk);

		print_counts();
		if (err_bit + err_port + err_gc == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
